// ==== rtl/pipe_pkg.sv ====
package pipe_pkg;

    ////////////////////////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////////////////////////

    // Data word and PC
    typedef logic [31:0] word_t;

    // GPR number, $0..$31
    typedef logic [4:0]  reg_addr_t;

    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  shift_op_t;
    typedef logic [1:0]  exres_sel_t;

    // Branch sense
    typedef logic        cond_t;

    ////////////////////////////////////////////////////////////
    // Code constants
    ////////////////////////////////////////////////////////////

    // ALU operations
    localparam alu_op_t ALU_ADDU = 4'd0;
    localparam alu_op_t ALU_SUBU = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_NOR  = 4'd5;
    localparam alu_op_t ALU_SLT  = 4'd6;
    localparam alu_op_t ALU_SLTU = 4'd7;
    // Upper half from the immediate, lower half zero
    localparam alu_op_t ALU_LUI  = 4'd8;

    // Shifter kinds
    localparam shift_op_t SH_SLL = 2'd0;
    localparam shift_op_t SH_SRL = 2'd1;
    localparam shift_op_t SH_SRA = 2'd2;

    // EX result source
    localparam exres_sel_t RES_ALU   = 2'd0;
    localparam exres_sel_t RES_SHIFT = 2'd1;
    localparam exres_sel_t RES_MOVE  = 2'd2;

    // beq / bne
    localparam cond_t COND_EQ = 1'b0;
    localparam cond_t COND_NE = 1'b1;

endpackage

// ==== rtl/inst_decode.sv ====
module inst_decode import pipe_pkg::*; (
    input  word_t      instr,
    output reg_addr_t  rs_addr,
    output reg_addr_t  rt_addr,
    output reg_addr_t  rd_addr,
    output logic       reg_w,
    output logic       branch,
    output logic       b_sel,
    output logic       shamt_sel,
    output alu_op_t    alu_op,
    output shift_op_t  shift_op,
    output logic [4:0] shamt,
    output exres_sel_t exres_sel,
    output cond_t      condition,
    output logic       movz,
    output logic       movn,
    output word_t      imm_ext,
    output logic       nop
);

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // SPECIAL funct codes
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_MOVZ = 6'h0a;
    localparam logic [5:0] FN_MOVN = 6'h0b;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       known;
    logic       wr_raw;
    logic       use_rd;
    logic       zero_ext;
    shift_op_t  sh_kind;

    assign opcode  = instr[31:26];
    assign funct   = instr[5:0];
    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];
    assign shamt   = instr[10:6];

    // Shift kind from the low funct bits
    assign sh_kind = (funct[1:0] == 2'b11) ? SH_SRA :
                     (funct[1:0] == 2'b10) ? SH_SRL : SH_SLL;

    always_comb begin
        known     = 1'b1;
        wr_raw    = 1'b0;
        use_rd    = 1'b0;
        zero_ext  = 1'b0;
        branch    = 1'b0;
        b_sel     = 1'b0;
        shamt_sel = 1'b0;
        alu_op    = ALU_ADDU;
        shift_op  = SH_SLL;
        exres_sel = RES_ALU;
        condition = COND_EQ;
        movz      = 1'b0;
        movn      = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                use_rd = 1'b1;
                wr_raw = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADDU;
                    FN_SUBU: alu_op = ALU_SUBU;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        exres_sel = RES_SHIFT;
                        shift_op  = sh_kind;
                    end
                    // Variable shifts take the amount from rs
                    FN_SLLV, FN_SRLV, FN_SRAV: begin
                        exres_sel = RES_SHIFT;
                        shift_op  = sh_kind;
                        shamt_sel = 1'b1;
                    end
                    FN_MOVZ: begin
                        exres_sel = RES_MOVE;
                        movz      = 1'b1;
                    end
                    FN_MOVN: begin
                        exres_sel = RES_MOVE;
                        movn      = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                wr_raw = 1'b1;
                b_sel  = 1'b1;
                case (opcode)
                    OP_SLTI:  alu_op = ALU_SLT;
                    OP_SLTIU: alu_op = ALU_SLTU;
                    OP_ANDI:  alu_op = ALU_AND;
                    OP_ORI:   alu_op = ALU_OR;
                    OP_XORI:  alu_op = ALU_XOR;
                    OP_LUI:   alu_op = ALU_LUI;
                    default:  alu_op = ALU_ADDU;
                endcase
                // Logical immediates are zero extended
                zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI) ||
                           (opcode == OP_XORI) || (opcode == OP_LUI);
            end
            OP_BEQ: branch = 1'b1;
            OP_BNE: begin
                branch    = 1'b1;
                condition = COND_NE;
            end
            default: known = 1'b0;
        endcase
    end

    assign rd_addr = use_rd ? instr[15:11] : instr[20:16];
    assign imm_ext = zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    // A write to $0 does nothing, so it goes down the pipe as a nop
    assign nop   = !known || (wr_raw && (rd_addr == 5'd0));
    assign reg_w = wr_raw && !nop;

endmodule

// ==== rtl/reg_file.sv ====
module reg_file import pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      hold,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  logic      w_en,
    input  reg_addr_t w_addr,
    input  word_t     w_data,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [32];
    logic  do_write;

    // Only on a slot, never to $0
    assign do_write = w_en && !hold && (w_addr != 5'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (do_write) begin
            regs[w_addr] <= w_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports with write-through
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (rs_addr == 5'd0) begin
            rs_data = '0;
        end else if (do_write && (w_addr == rs_addr)) begin
            rs_data = w_data;
        end else begin
            rs_data = regs[rs_addr];
        end
    end

    always_comb begin
        if (rt_addr == 5'd0) begin
            rt_data = '0;
        end else if (do_write && (w_addr == rt_addr)) begin
            rt_data = w_data;
        end else begin
            rt_data = regs[rt_addr];
        end
    end

endmodule

// ==== rtl/idex_reg.sv ====
module idex_reg import pipe_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       hold,
    input  logic       flush,
    input  logic       id_valid,
    input  logic       id_nop,
    input  logic       id_reg_w,
    input  logic       id_branch,
    input  logic       id_b_sel,
    input  logic       id_shamt_sel,
    input  alu_op_t    id_alu_op,
    input  shift_op_t  id_shift_op,
    input  logic [4:0] id_shamt,
    input  exres_sel_t id_exres_sel,
    input  cond_t      id_condition,
    input  logic       id_movz,
    input  logic       id_movn,
    input  word_t      id_imm_ext,
    input  reg_addr_t  id_rs_addr,
    input  reg_addr_t  id_rt_addr,
    input  reg_addr_t  id_rd_addr,
    input  word_t      id_op_a,
    input  word_t      id_op_b,
    input  word_t      id_pc,
    output logic       ex_nop,
    output logic       ex_reg_w,
    output logic       ex_branch,
    output logic       ex_b_sel,
    output logic       ex_shamt_sel,
    output alu_op_t    ex_alu_op,
    output shift_op_t  ex_shift_op,
    output logic [4:0] ex_shamt,
    output exres_sel_t ex_exres_sel,
    output cond_t      ex_condition,
    output logic       ex_movz,
    output logic       ex_movn,
    output word_t      ex_imm_ext,
    output reg_addr_t  ex_rs_addr,
    output reg_addr_t  ex_rt_addr,
    output reg_addr_t  ex_rd_addr,
    output word_t      ex_op_a,
    output word_t      ex_op_b,
    output word_t      ex_pc
);

    ////////////////////////////////////////////////////////////
    // Enables, bubble on reset or on a flushed slot
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n || (flush && !hold)) begin
            ex_nop    <= 1'b1;
            ex_reg_w  <= 1'b0;
            ex_branch <= 1'b0;
            ex_movz   <= 1'b0;
            ex_movn   <= 1'b0;
        end else if (!hold) begin
            // Empty input slot goes in as a nop
            ex_nop    <= id_nop || !id_valid;
            ex_reg_w  <= id_reg_w && id_valid;
            ex_branch <= id_branch && id_valid;
            ex_movz   <= id_movz && id_valid;
            ex_movn   <= id_movn && id_valid;
        end
    end

    // Operands and selects, meaningless under a bubble
    always_ff @(posedge clk) begin
        if (!hold) begin
            ex_b_sel     <= id_b_sel;
            ex_shamt_sel <= id_shamt_sel;
            ex_alu_op    <= id_alu_op;
            ex_shift_op  <= id_shift_op;
            ex_shamt     <= id_shamt;
            ex_exres_sel <= id_exres_sel;
            ex_condition <= id_condition;
            ex_imm_ext   <= id_imm_ext;
            ex_rs_addr   <= id_rs_addr;
            ex_rt_addr   <= id_rt_addr;
            ex_rd_addr   <= id_rd_addr;
            ex_op_a      <= id_op_a;
            ex_op_b      <= id_op_b;
            ex_pc        <= id_pc;
        end
    end

endmodule

// ==== rtl/exec_unit.sv ====
module exec_unit import pipe_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       hold,
    input  logic       ex_nop,
    input  logic       ex_reg_w,
    input  logic       ex_branch,
    input  logic       ex_b_sel,
    input  logic       ex_shamt_sel,
    input  alu_op_t    ex_alu_op,
    input  shift_op_t  ex_shift_op,
    input  logic [4:0] ex_shamt,
    input  exres_sel_t ex_exres_sel,
    input  cond_t      ex_condition,
    input  logic       ex_movz,
    input  logic       ex_movn,
    input  word_t      ex_imm_ext,
    input  reg_addr_t  ex_rs_addr,
    input  reg_addr_t  ex_rt_addr,
    input  reg_addr_t  ex_rd_addr,
    input  word_t      ex_op_a,
    input  word_t      ex_op_b,
    input  word_t      ex_pc,
    output logic       branch_taken,
    output logic       wb_en,
    output reg_addr_t  wb_addr,
    output word_t      wb_data,
    output logic       redirect_valid,
    output word_t      redirect_pc
);

    word_t      src_a;
    word_t      src_b;
    word_t      alu_b;
    word_t      alu_res;
    word_t      shift_res;
    word_t      result;
    word_t      target;
    logic [4:0] sh_amt;
    logic       move_ok;
    logic       wr_next;

    // Forward the previous instruction's result from EX/WB
    assign src_a = (wb_en && (wb_addr == ex_rs_addr) && (ex_rs_addr != 5'd0)) ? wb_data : ex_op_a;
    assign src_b = (wb_en && (wb_addr == ex_rt_addr) && (ex_rt_addr != 5'd0)) ? wb_data : ex_op_b;

    assign alu_b = ex_b_sel ? ex_imm_ext : src_b;

    always_comb begin
        case (ex_alu_op)
            ALU_ADDU: alu_res = src_a + alu_b;
            ALU_SUBU: alu_res = src_a - alu_b;
            ALU_AND:  alu_res = src_a & alu_b;
            ALU_OR:   alu_res = src_a | alu_b;
            ALU_XOR:  alu_res = src_a ^ alu_b;
            ALU_NOR:  alu_res = ~(src_a | alu_b);
            ALU_SLT:  alu_res = {31'd0, $signed(src_a) < $signed(alu_b)};
            ALU_SLTU: alu_res = {31'd0, src_a < alu_b};
            ALU_LUI:  alu_res = {alu_b[15:0], 16'h0000};
            default:  alu_res = '0;
        endcase
    end

    // Shift rt by shamt or by rs[4:0]
    assign sh_amt = ex_shamt_sel ? src_a[4:0] : ex_shamt;

    always_comb begin
        case (ex_shift_op)
            SH_SRL:  shift_res = src_b >> sh_amt;
            SH_SRA:  shift_res = $unsigned($signed(src_b) >>> sh_amt);
            default: shift_res = src_b << sh_amt;
        endcase
    end

    always_comb begin
        case (ex_exres_sel)
            RES_SHIFT: result = shift_res;
            RES_MOVE:  result = src_a;
            default:   result = alu_res;
        endcase
    end

    // movz/movn test rt
    assign move_ok = (ex_exres_sel != RES_MOVE) ||
                     (ex_movz && (src_b == '0)) ||
                     (ex_movn && (src_b != '0));
    assign wr_next = ex_reg_w && !ex_nop && move_ok;

    ////////////////////////////////////////////////////////////
    // Branch resolve
    ////////////////////////////////////////////////////////////

    assign target = ex_pc + 32'd4 + {ex_imm_ext[29:0], 2'b00};

    assign branch_taken = ex_branch && !ex_nop && !hold &&
                          ((ex_condition == COND_EQ) ? (src_a == src_b) : (src_a != src_b));

    // EX/WB register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_en          <= 1'b0;
            redirect_valid <= 1'b0;
        end else if (!hold) begin
            wb_en          <= wr_next;
            redirect_valid <= branch_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            wb_addr     <= ex_rd_addr;
            wb_data     <= result;
            redirect_pc <= target;
        end
    end

endmodule

// ==== rtl/int_pipe_top.sv ====
module int_pipe_top import pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      hold,
    input  logic      instr_valid,
    input  word_t     instr,
    input  word_t     instr_pc,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output word_t     wb_data,
    output logic      redirect_valid,
    output word_t     redirect_pc
);

    // ID stage
    reg_addr_t  rs_addr;
    reg_addr_t  rt_addr;
    reg_addr_t  rd_addr;
    logic       reg_w;
    logic       branch;
    logic       b_sel;
    logic       shamt_sel;
    alu_op_t    alu_op;
    shift_op_t  shift_op;
    logic [4:0] shamt;
    exres_sel_t exres_sel;
    cond_t      condition;
    logic       movz;
    logic       movn;
    word_t      imm_ext;
    logic       nop;
    word_t      rs_data;
    word_t      rt_data;

    // EX stage
    logic       ex_nop;
    logic       ex_reg_w;
    logic       ex_branch;
    logic       ex_b_sel;
    logic       ex_shamt_sel;
    alu_op_t    ex_alu_op;
    shift_op_t  ex_shift_op;
    logic [4:0] ex_shamt;
    exres_sel_t ex_exres_sel;
    cond_t      ex_condition;
    logic       ex_movz;
    logic       ex_movn;
    word_t      ex_imm_ext;
    reg_addr_t  ex_rs_addr;
    reg_addr_t  ex_rt_addr;
    reg_addr_t  ex_rd_addr;
    word_t      ex_op_a;
    word_t      ex_op_b;
    word_t      ex_pc;
    logic       branch_taken;

    inst_decode inst_decode_inst (.*);

    // Write port fed back from EX/WB
    reg_file reg_file_inst (
        .w_en   (wb_en),
        .w_addr (wb_addr),
        .w_data (wb_data),
        .*
    );

    idex_reg idex_reg_inst (
        .flush        (branch_taken),
        .id_valid     (instr_valid),
        .id_nop       (nop),
        .id_reg_w     (reg_w),
        .id_branch    (branch),
        .id_b_sel     (b_sel),
        .id_shamt_sel (shamt_sel),
        .id_alu_op    (alu_op),
        .id_shift_op  (shift_op),
        .id_shamt     (shamt),
        .id_exres_sel (exres_sel),
        .id_condition (condition),
        .id_movz      (movz),
        .id_movn      (movn),
        .id_imm_ext   (imm_ext),
        .id_rs_addr   (rs_addr),
        .id_rt_addr   (rt_addr),
        .id_rd_addr   (rd_addr),
        .id_op_a      (rs_data),
        .id_op_b      (rt_data),
        .id_pc        (instr_pc),
        .*
    );

    exec_unit exec_unit_inst (.*);

endmodule

// ==== testbench/int_pipe_tb.sv ====
module int_pipe_tb import pipe_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_SLOTS   = 3000;
    localparam int DRAIN_SLOTS = 6;
    // Four clock periods per slot, reset and drain included
    localparam int TIMEOUT_NS  = (NUM_SLOTS + DRAIN_SLOTS + 10) * 20 * 4;

    logic      clk;
    logic      rst_n;
    logic      hold;
    logic      instr_valid;
    word_t     instr;
    word_t     instr_pc;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      redirect_valid;
    word_t     redirect_pc;

    // Model state
    word_t       model_regs [32];
    logic        squash_next;
    // {is_redirect, addr, data}
    logic [37:0] expect_q [$];
    logic [31:0] rng_state;
    logic        slot_edge;
    int          error_count;
    int          check_count;
    int          wb_seen;
    int          redirect_seen;

    int_pipe_top int_pipe_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Instruction builders
    ////////////////////////////////////////////////////////////

    function automatic word_t encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] rd, input logic [4:0] sa,
                                       input logic [5:0] funct);
        return {6'h00, rs, rt, rd, sa, funct};
    endfunction

    function automatic word_t encode_i(input logic [5:0] op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t random_instr();
        logic [31:0] r;
        logic [31:0] f;
        logic [5:0]  funct;
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        word_t       ins;
        r  = next_rand();
        f  = next_rand();
        // Only $0..$7, so dependencies are frequent
        rs = {2'b00, f[2:0]};
        rt = {2'b00, f[5:3]};
        case (r[7:4])
            4'd0:    funct = 6'h21;
            4'd1:    funct = 6'h23;
            4'd2:    funct = 6'h24;
            4'd3:    funct = 6'h25;
            4'd4:    funct = 6'h26;
            4'd5:    funct = 6'h27;
            4'd6:    funct = 6'h2a;
            4'd7:    funct = 6'h2b;
            4'd8:    funct = 6'h00;
            4'd9:    funct = 6'h02;
            4'd10:   funct = 6'h03;
            4'd11:   funct = 6'h04;
            4'd12:   funct = 6'h06;
            4'd13:   funct = 6'h07;
            4'd14:   funct = 6'h0a;
            default: funct = 6'h0b;
        endcase
        case (r[10:8])
            3'd1:    op = 6'h0a;
            3'd2:    op = 6'h0b;
            3'd3:    op = 6'h0c;
            3'd4:    op = 6'h0d;
            3'd5:    op = 6'h0e;
            3'd6:    op = 6'h0f;
            default: op = 6'h09;
        endcase
        if (r[3:0] < 4'd8) begin
            ins = encode_r(rs, rt, {2'b00, f[8:6]}, f[13:9], funct);
        end else if (r[3:0] < 4'd12) begin
            ins = encode_i(op, rs, rt, f[31:16]);
        end else if (r[3:0] < 4'd14) begin
            // Same register on both sides now and then
            if (r[11]) begin
                rt = rs;
            end
            ins = encode_i(r[12] ? 6'h05 : 6'h04, rs, rt, f[31:16]);
        end else if (r[3:0] == 4'd14) begin
            ins = encode_i(6'h3f, rs, rt, f[31:16]);
        end else begin
            ins = encode_r(rs, rt, 5'd1, 5'd0, 6'h01);
        end
        return ins;
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model, one accepted slot at a time
    ////////////////////////////////////////////////////////////

    task automatic model_slot(input logic valid, input word_t ins, input word_t pc);
        logic [5:0] op;
        logic [5:0] funct;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [4:0] dest;
        word_t      a;
        word_t      b;
        word_t      sext;
        word_t      zext;
        word_t      res;
        logic       write;
        logic       taken;
        if (squash_next) begin
            // Slot right after a taken branch
            squash_next = 1'b0;
            return;
        end
        if (!valid) begin
            return;
        end
        op    = ins[31:26];
        rs    = ins[25:21];
        rt    = ins[20:16];
        rd    = ins[15:11];
        sa    = ins[10:6];
        funct = ins[5:0];
        a     = model_regs[rs];
        b     = model_regs[rt];
        sext  = {{16{ins[15]}}, ins[15:0]};
        zext  = {16'h0000, ins[15:0]};
        write = 1'b1;
        dest  = rt;
        res   = '0;
        taken = 1'b0;
        case (op)
            6'h00: begin
                dest = rd;
                case (funct)
                    6'h21:   res = a + b;
                    6'h23:   res = a - b;
                    6'h24:   res = a & b;
                    6'h25:   res = a | b;
                    6'h26:   res = a ^ b;
                    6'h27:   res = ~(a | b);
                    6'h2a:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h2b:   res = (a < b) ? 32'd1 : 32'd0;
                    6'h00:   res = b << sa;
                    6'h02:   res = b >> sa;
                    6'h03:   res = $signed(b) >>> sa;
                    6'h04:   res = b << a[4:0];
                    6'h06:   res = b >> a[4:0];
                    6'h07:   res = $signed(b) >>> a[4:0];
                    6'h0a: begin
                        res   = a;
                        write = (b == 32'd0);
                    end
                    6'h0b: begin
                        res   = a;
                        write = (b != 32'd0);
                    end
                    default: write = 1'b0;
                endcase
            end
            6'h09:   res = a + sext;
            6'h0a:   res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            6'h0b:   res = (a < sext) ? 32'd1 : 32'd0;
            6'h0c:   res = a & zext;
            6'h0d:   res = a | zext;
            6'h0e:   res = a ^ zext;
            6'h0f:   res = {ins[15:0], 16'h0000};
            6'h04, 6'h05: begin
                write = 1'b0;
                taken = (op == 6'h04) ? (a == b) : (a != b);
            end
            default: write = 1'b0;
        endcase
        if (write && (dest != 5'd0)) begin
            model_regs[dest] = res;
            expect_q.push_back({1'b0, dest, res});
        end
        if (taken) begin
            expect_q.push_back({1'b1, 5'd0, pc + 32'd4 + {sext[29:0], 2'b00}});
            squash_next = 1'b1;
        end
    endtask

    task automatic take_event(input logic is_redirect);
        logic [37:0] ev;
        if (expect_q.size() == 0) begin
            error_count++;
            $display("Unexpected %s from the DUT, the model has nothing pending",
                     is_redirect ? "redirect" : "write-back");
            return;
        end
        ev = expect_q.pop_front();
        if (ev[37] != is_redirect) begin
            error_count++;
            $display("Out of order: the model expected a %s but the DUT gave a %s",
                     ev[37] ? "redirect" : "write-back",
                     is_redirect ? "redirect" : "write-back");
        end else if (is_redirect) begin
            redirect_seen++;
            check_value($sformatf("redirect_pc #%0d", redirect_seen), ev[31:0], redirect_pc);
        end else begin
            wb_seen++;
            check_value($sformatf("wb_addr #%0d", wb_seen), {27'd0, ev[36:32]},
                        {27'd0, wb_addr});
            check_value($sformatf("wb_data #%0d", wb_seen), ev[31:0], wb_data);
        end
    endtask

    // Outputs are new only after a slot edge
    always @(posedge clk) begin
        slot_edge <= rst_n && !hold;
    end

    always @(negedge clk) begin
        if (slot_edge && wb_en) begin
            take_event(1'b0);
        end
        if (slot_edge && redirect_valid) begin
            take_event(1'b1);
        end
    end

    initial begin
        word_t       pc;
        logic [31:0] r;
        int          slots;
        rng_state     = 32'hbe72;
        error_count   = 0;
        check_count   = 0;
        wb_seen       = 0;
        redirect_seen = 0;
        squash_next   = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        rst_n       = 1'b0;
        hold        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = '0;
        pc          = 32'h0040_0000;
        slots       = 0;
        repeat (10) @(posedge clk);
        #2;
        // Both pulses low out of reset
        check_value("wb_en after reset", 32'd0, {31'd0, wb_en});
        check_value("redirect_valid after reset", 32'd0, {31'd0, redirect_valid});
        rst_n = 1'b1;
        while (slots < NUM_SLOTS) begin
            r = next_rand();
            if (r[2:0] == 3'd0) begin
                // Junk on the inputs while frozen
                hold        = 1'b1;
                instr_valid = r[3];
                instr       = next_rand();
            end else begin
                hold        = 1'b0;
                instr_valid = (r[6:4] != 3'd0);
                instr       = random_instr();
                instr_pc    = pc;
                model_slot(instr_valid, instr, pc);
                pc = pc + 32'd4;
                slots++;
            end
            @(posedge clk);
            #2;
        end
        // Let the last results drain out
        hold        = 1'b0;
        instr_valid = 1'b0;
        repeat (DRAIN_SLOTS) begin
            model_slot(1'b0, instr, pc);
            @(posedge clk);
            #2;
        end
        @(negedge clk);
        if (expect_q.size() != 0) begin
            error_count++;
            $display("%0d expected results never came out of the DUT", expect_q.size());
        end
        $display("Checks %0d, write-backs %0d, redirects %0d, errors %0d",
                 check_count, wb_seen, redirect_seen, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout, the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Checks %0d, errors %0d", check_count, error_count);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/pipe_pkg.sv
rtl/inst_decode.sv
rtl/reg_file.sv
rtl/idex_reg.sv
rtl/exec_unit.sv
rtl/int_pipe_top.sv
testbench/int_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 \
    --top-module int_pipe_tb \
    -f compile.f \
    -o int_pipe_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/int_pipe_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -x ">>> PASS" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed, see $LOG"
exit 1
